// File: hdl/core_pkg.sv
`default_nettype none

// Machine widths shared by every stage of the core
package core_pkg;

  localparam int xlen = 32;       // Data and address width of RV32I
  localparam int reg_count = 32;  // Architectural registers x0 to x31
  localparam int reg_id_w = $clog2(reg_count);
  localparam int pc_step = 4;     // Every RV32I instruction is one 32-bit word

  // Data or address word
  typedef logic [xlen-1:0] word_t;

  // Index into the register file
  typedef logic [reg_id_w-1:0] reg_id_t;

  // Raw instruction as fetched, before any field is split out
  typedef logic [xlen-1:0] instr_t;

endpackage

`default_nettype wire

// File: hdl/isa_pkg.sv
`default_nettype none

// RV32I encoding facts: opcodes, field positions and the decoded enums
package isa_pkg;

  localparam int opcode_w = 7;
  localparam int funct3_w = 3;
  localparam int funct7_w = 7;

  // Lowest bit of each field in the 32-bit instruction word
  localparam int rd_lsb = 7;
  localparam int funct3_lsb = 12;
  localparam int rs1_lsb = 15;
  localparam int rs2_lsb = 20;
  localparam int funct7_lsb = 25;

  typedef logic [opcode_w-1:0] opcode_t;

  localparam opcode_t op_lui = 7'b0110111;
  localparam opcode_t op_auipc = 7'b0010111;
  localparam opcode_t op_jal = 7'b1101111;
  localparam opcode_t op_jalr = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_load = 7'b0000011;
  localparam opcode_t op_store = 7'b0100011;
  localparam opcode_t op_op_imm = 7'b0010011;
  localparam opcode_t op_op = 7'b0110011;

  // funct3 values of the arithmetic group, the same for OP and OP-IMM
  localparam logic [funct3_w-1:0] f3_add_sub = 3'b000;
  localparam logic [funct3_w-1:0] f3_sll = 3'b001;
  localparam logic [funct3_w-1:0] f3_slt = 3'b010;
  localparam logic [funct3_w-1:0] f3_sltu = 3'b011;
  localparam logic [funct3_w-1:0] f3_xor = 3'b100;
  localparam logic [funct3_w-1:0] f3_srl_sra = 3'b101;
  localparam logic [funct3_w-1:0] f3_or = 3'b110;
  localparam logic [funct3_w-1:0] f3_and = 3'b111;

  // funct7 that turns ADD into SUB and a logical right shift into an arithmetic one
  localparam logic [funct7_w-1:0] f7_alt = 7'b0100000;

  // Instruction format, which also selects the immediate layout
  typedef enum logic [2:0] {
    R_TYPE,
    I_TYPE,
    S_TYPE,
    B_TYPE,
    U_TYPE,
    J_TYPE
  } encoding_t;

  typedef enum logic [3:0] {
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_ADD,
    ALU_SUB,
    ALU_SHIFT_LEFT,
    ALU_SHIFT_RIGHT,
    ALU_SHIFT_RIGHT_AR,
    ALU_LESS_THAN_UNSIGNED,
    ALU_LESS_THAN_SIGNED
  } alu_op_t;

endpackage

`default_nettype wire

// File: hdl/fetch_if.sv
`default_nettype none
`timescale 1ns/1ns

// Tagged instruction handed from fetch to the IF/ID register
interface fetch_if;
  import core_pkg::*;

  logic   valid;        // One-cycle strobe per new instruction
  instr_t instruction;
  word_t  pc;           // Address the instruction was fetched from
  logic   flush;        // Taken branch, kills whatever the buffer holds

  modport producer (output valid, instruction, pc, flush);
  modport consumer (input valid, instruction, pc, flush);

endinterface

`default_nettype wire

// File: hdl/control_if.sv
`default_nettype none
`timescale 1ns/1ns

// Decoded control fields, purely combinational from the instruction in ID
interface control_if;
  import core_pkg::*;
  import isa_pkg::*;

  encoding_t encoding;       // Format, steers the immediate generator
  alu_op_t   alu_op;
  logic      alu_src;        // Second ALU operand is the immediate
  logic      mem_read;
  logic      mem_write;
  logic      mem_to_reg;     // Write-back value comes from memory
  logic      is_branch;
  logic      reg_write;
  reg_id_t   write_back_id;  // Destination register rd

  modport driver (
    output encoding, alu_op, alu_src, mem_read, mem_write, mem_to_reg, is_branch,
    output reg_write, write_back_id
  );

  modport reader (
    input encoding, alu_op, alu_src, mem_read, mem_write, mem_to_reg, is_branch,
    input reg_write, write_back_id
  );

endinterface

`default_nettype wire

// File: hdl/fetch_unit.sv
`default_nettype none
`timescale 1ns/1ns

module fetch_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             instr_valid,    // A new word is on instr_data this cycle
  input  core_pkg::instr_t instr_data,
  input  logic             branch_taken,   // Redirect from a resolved branch
  input  core_pkg::word_t  branch_target,
  fetch_if.producer        fetch
);
  import core_pkg::*;

  word_t  pc;           // Address of the next word to arrive
  logic   valid_q;
  instr_t instr_q;
  word_t  pc_tag_q;     // Address captured together with instr_q

  // Control state, a branch wins over an arriving word, which is the wrong path
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc      <= '0;
      valid_q <= 1'b0;
    end else if (branch_taken) begin
      pc      <= branch_target;
      valid_q <= 1'b0;    // Drop the word presented with the branch
    end else if (instr_valid) begin
      pc      <= pc + word_t'(pc_step);
      valid_q <= 1'b1;
    end else begin
      valid_q <= 1'b0;    // Strobe lasts a single cycle
    end
  end

  // Payload only moves when a word is accepted
  always_ff @(posedge clk) begin
    if (instr_valid && !branch_taken) begin
      instr_q  <= instr_data;
      pc_tag_q <= pc;
    end
  end

  assign fetch.valid = valid_q;
  assign fetch.instruction = instr_q;
  assign fetch.pc = pc_tag_q;
  assign fetch.flush = branch_taken;  // Same cycle, so IF/ID drops its entry at this edge

endmodule

`default_nettype wire

// File: hdl/if_id_register.sv
`default_nettype none
`timescale 1ns/1ns

module if_id_register (
  input  logic              clk,
  input  logic              rst_n,
  fetch_if.consumer         fetch,
  output core_pkg::instr_t  instruction,  // Word presented to decode
  output core_pkg::word_t   pc,
  output logic              valid         // High for one cycle per buffered word
);
  import core_pkg::*;

  instr_t instr_q;
  word_t  pc_q;
  logic   valid_q;

  // Flush beats capture, an in-flight word from the old path never reaches decode
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (fetch.flush) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= fetch.valid;  // Drops again when no new entry follows
    end
  end

  // Data bits stay put on a flush and the cleared valid makes them inert
  always_ff @(posedge clk) begin
    if (fetch.valid && !fetch.flush) begin
      instr_q <= fetch.instruction;
      pc_q    <= fetch.pc;
    end
  end

  assign instruction = instr_q;
  assign pc = pc_q;
  assign valid = valid_q;

endmodule

`default_nettype wire

// File: hdl/control.sv
`default_nettype none
`timescale 1ns/1ns

module control (
  input  core_pkg::instr_t instruction,
  control_if.driver        ctrl
);
  import core_pkg::*;
  import isa_pkg::*;

  opcode_t             opcode;
  logic [funct3_w-1:0] funct3;
  logic [funct7_w-1:0] funct7;
  alu_op_t             arith_op;   // Operation of the OP and OP-IMM groups
  alu_op_t             branch_op;  // Comparison behind the branch condition

  assign opcode = instruction[opcode_w-1:0];
  assign funct3 = instruction[funct3_lsb +: funct3_w];
  assign funct7 = instruction[funct7_lsb +: funct7_w];

  // rd sits in the same place in every format that has one
  assign ctrl.write_back_id = instruction[rd_lsb +: reg_id_w];

  always_comb begin
    case (funct3)
      // SUB only exists in the register form, ADDI keeps immediate bits in funct7
      f3_add_sub: arith_op = (opcode == op_op && funct7 == f7_alt) ? ALU_SUB : ALU_ADD;
      f3_sll:     arith_op = ALU_SHIFT_LEFT;
      f3_slt:     arith_op = ALU_LESS_THAN_SIGNED;
      f3_sltu:    arith_op = ALU_LESS_THAN_UNSIGNED;
      f3_xor:     arith_op = ALU_XOR;
      f3_srl_sra: arith_op = (funct7 == f7_alt) ? ALU_SHIFT_RIGHT_AR : ALU_SHIFT_RIGHT;
      f3_or:      arith_op = ALU_OR;
      default:    arith_op = ALU_AND;
    endcase
  end

  // BEQ and BNE test for zero difference, the others compare by sign or not
  always_comb begin
    if (!funct3[2]) begin
      branch_op = ALU_SUB;
    end else if (funct3[1]) begin
      branch_op = ALU_LESS_THAN_UNSIGNED;  // BLTU and BGEU
    end else begin
      branch_op = ALU_LESS_THAN_SIGNED;    // BLT and BGE
    end
  end

  always_comb begin
    // An unknown opcode leaves these in place and so does nothing to state
    ctrl.encoding   = R_TYPE;
    ctrl.alu_op     = ALU_ADD;
    ctrl.alu_src    = 1'b0;
    ctrl.mem_read   = 1'b0;
    ctrl.mem_write  = 1'b0;
    ctrl.mem_to_reg = 1'b0;
    ctrl.is_branch  = 1'b0;
    ctrl.reg_write  = 1'b0;
    case (opcode)
      op_lui, op_auipc: begin
        ctrl.encoding  = U_TYPE;
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      op_jal: begin
        ctrl.encoding  = J_TYPE;
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;  // Link address goes to rd
      end
      op_jalr: begin
        ctrl.encoding  = I_TYPE;
        ctrl.alu_src   = 1'b1;  // Target is rs1 plus offset
        ctrl.reg_write = 1'b1;
      end
      op_branch: begin
        // The ALU compares rs1 with rs2, the offset only feeds the PC adder
        ctrl.encoding  = B_TYPE;
        ctrl.alu_op    = branch_op;
        ctrl.is_branch = 1'b1;
      end
      op_load: begin
        ctrl.encoding   = I_TYPE;
        ctrl.alu_src    = 1'b1;  // Address is rs1 plus offset
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.reg_write  = 1'b1;
      end
      op_store: begin
        ctrl.encoding  = S_TYPE;
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      op_op_imm: begin
        ctrl.encoding  = I_TYPE;
        ctrl.alu_op    = arith_op;
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      op_op: begin
        ctrl.alu_op    = arith_op;
        ctrl.reg_write = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/imm_gen.sv
`default_nettype none
`timescale 1ns/1ns

module imm_gen (
  input  core_pkg::instr_t instruction,
  control_if.reader        ctrl,            // Only the decoded format is used here
  output core_pkg::word_t  immediate_data
);
  import isa_pkg::*;

  // Bit 31 is the sign in every format, which keeps the extension cheap
  always_comb begin
    case (ctrl.encoding)
      I_TYPE: immediate_data = {{20{instruction[31]}}, instruction[31:20]};
      S_TYPE: immediate_data = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
      B_TYPE: begin
        // Offset counts in half words so bit 0 is always zero
        immediate_data = {{19{instruction[31]}}, instruction[31], instruction[7],
                          instruction[30:25], instruction[11:8], 1'b0};
      end
      U_TYPE: immediate_data = {instruction[31:12], 12'b0};  // Upper twenty bits
      J_TYPE: begin
        immediate_data = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                          instruction[20], instruction[30:21], 1'b0};
      end
      default: immediate_data = '0;  // R-type has no immediate
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/registers.sv
`default_nettype none
`timescale 1ns/1ns

module registers (
  input  logic              clk,
  input  logic              rst_n,
  input  core_pkg::reg_id_t read1_id,
  input  core_pkg::reg_id_t read2_id,
  input  logic              write_en,
  input  core_pkg::reg_id_t write_id,
  input  core_pkg::word_t   write_data,
  output core_pkg::word_t   read1_data,
  output core_pkg::word_t   read2_data
);
  import core_pkg::*;

  word_t regs [reg_count];  // Entry 0 is never written

  // Architectural state starts at zero after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      regs <= '{default: '0};
    end else if (write_en && write_id != '0) begin
      regs[write_id] <= write_data;  // Writes to x0 are dropped
    end
  end

  // Reads are asynchronous, x0 is forced to zero on both ports
  assign read1_data = (read1_id == '0) ? '0 : regs[read1_id];
  assign read2_data = (read2_id == '0) ? '0 : regs[read2_id];

endmodule

`default_nettype wire

// File: hdl/instruction_decode_stage.sv
`default_nettype none
`timescale 1ns/1ns

module instruction_decode_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  core_pkg::instr_t  instruction,     // Word held by the IF/ID register
  input  logic              reg_write,       // Write-back port from the last stage
  input  core_pkg::reg_id_t write_id,
  input  core_pkg::word_t   write_data,
  control_if.reader         ctrl,            // Driven by control beside this stage
  output core_pkg::word_t   immediate_data,
  output core_pkg::word_t   read1_data,
  output core_pkg::word_t   read2_data,
  output core_pkg::reg_id_t rs1,
  output core_pkg::reg_id_t rs2
);
  import core_pkg::*;
  import isa_pkg::*;

  word_t read1_regs;  // Register file value before forwarding
  word_t read2_regs;
  logic  wb_active;   // A write-back that really changes state this cycle

  // Source indices are decoded for every format and simply unused where absent
  assign rs1 = instruction[rs1_lsb +: reg_id_w];
  assign rs2 = instruction[rs2_lsb +: reg_id_w];

  assign wb_active = reg_write && (write_id != '0);

  // The write lands at the next edge, so a matching read takes the new value now
  assign read1_data = (wb_active && write_id == rs1) ? write_data : read1_regs;
  assign read2_data = (wb_active && write_id == rs2) ? write_data : read2_regs;

  registers registers_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .read1_id   (rs1),
    .read2_id   (rs2),
    .write_en   (reg_write),
    .write_id   (write_id),
    .write_data (write_data),
    .read1_data (read1_regs),
    .read2_data (read2_regs)
  );

  imm_gen imm_gen_inst (
    .instruction    (instruction),
    .ctrl           (ctrl),
    .immediate_data (immediate_data)
  );

endmodule

`default_nettype wire

// File: hdl/decode_top.sv
`default_nettype none
`timescale 1ns/1ns

module decode_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               instr_valid,
  input  core_pkg::instr_t   instr_data,
  input  logic               branch_taken,
  input  core_pkg::word_t    branch_target,
  input  logic               reg_write,       // Write-back from the end of the pipe
  input  core_pkg::reg_id_t  write_id,
  input  core_pkg::word_t    write_data,
  output logic               id_valid,
  output core_pkg::word_t    id_pc,
  output isa_pkg::encoding_t encoding,
  output isa_pkg::alu_op_t   alu_op,
  output logic               alu_src,
  output logic               mem_read,
  output logic               mem_write,
  output logic               mem_to_reg,
  output logic               is_branch,
  output logic               ctrl_reg_write,  // Decoded reg_write of the ID instruction
  output core_pkg::reg_id_t  write_back_id,
  output core_pkg::word_t    immediate_data,
  output core_pkg::word_t    read1_data,
  output core_pkg::word_t    read2_data,
  output core_pkg::reg_id_t  rs1,
  output core_pkg::reg_id_t  rs2
);
  import core_pkg::*;

  instr_t id_instruction;  // Word in the IF/ID register

  fetch_if   fetch_bus ();
  control_if ctrl_bus ();

  fetch_unit fetch_unit_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid   (instr_valid),
    .instr_data    (instr_data),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .fetch         (fetch_bus.producer)
  );

  if_id_register if_id_register_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch       (fetch_bus.consumer),
    .instruction (id_instruction),
    .pc          (id_pc),
    .valid       (id_valid)
  );

  control control_inst (
    .instruction (id_instruction),
    .ctrl        (ctrl_bus.driver)
  );

  instruction_decode_stage instruction_decode_stage_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .instruction    (id_instruction),
    .reg_write      (reg_write),
    .write_id       (write_id),
    .write_data     (write_data),
    .ctrl           (ctrl_bus.reader),
    .immediate_data (immediate_data),
    .read1_data     (read1_data),
    .read2_data     (read2_data),
    .rs1            (rs1),
    .rs2            (rs2)
  );

  // Control fields leave the chip as separate pins
  assign encoding = ctrl_bus.encoding;
  assign alu_op = ctrl_bus.alu_op;
  assign alu_src = ctrl_bus.alu_src;
  assign mem_read = ctrl_bus.mem_read;
  assign mem_write = ctrl_bus.mem_write;
  assign mem_to_reg = ctrl_bus.mem_to_reg;
  assign is_branch = ctrl_bus.is_branch;
  assign ctrl_reg_write = ctrl_bus.reg_write;
  assign write_back_id = ctrl_bus.write_back_id;

endmodule

`default_nettype wire

// File: tb/decode_top_tb.sv
`timescale 1ns/1ns
`default_nettype none

module decode_top_tb;
  import core_pkg::*;
  import isa_pkg::*;

  localparam int clk_period = 40;
  localparam int max_wait = 8;   // Cycles a wait may take before the run gives up
  localparam int max_rows = 32;

  // Flag order is {alu_src, mem_read, mem_write, mem_to_reg, is_branch, reg_write}
  localparam logic [5:0] fl_none = 6'b000000;
  localparam logic [5:0] fl_rw = 6'b000001;
  localparam logic [5:0] fl_imm_rw = 6'b100001;
  localparam logic [5:0] fl_load = 6'b110101;
  localparam logic [5:0] fl_store = 6'b101000;
  localparam logic [5:0] fl_branch = 6'b000010;

  logic      clk;
  logic      rst_n;
  logic      instr_valid;
  instr_t    instr_data;
  logic      branch_taken;
  word_t     branch_target;
  logic      reg_write;
  reg_id_t   write_id;
  word_t     write_data;
  logic      id_valid;
  word_t     id_pc;
  encoding_t encoding;
  alu_op_t   alu_op;
  logic      alu_src;
  logic      mem_read;
  logic      mem_write;
  logic      mem_to_reg;
  logic      is_branch;
  logic      ctrl_reg_write;
  reg_id_t   write_back_id;
  word_t     immediate_data;
  word_t     read1_data;
  word_t     read2_data;
  reg_id_t   rs1;
  reg_id_t   rs2;

  // Stimulus table with one row per instruction
  string      name_tab [max_rows];
  instr_t     instr_tab [max_rows];
  encoding_t  enc_tab [max_rows];
  alu_op_t    alu_tab [max_rows];
  logic [5:0] flag_tab [max_rows];
  reg_id_t    rd_tab [max_rows];
  reg_id_t    rs1_tab [max_rows];
  reg_id_t    rs2_tab [max_rows];
  word_t      imm_tab [max_rows];
  int         row_count = 0;

  word_t lcg_state = 32'd27303;
  word_t reg_model [32];  // Expected architectural register contents
  word_t exp_pc;          // Address the next accepted word gets tagged with

  decode_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic word_t next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Encoders place the fields where the ISA puts them
  function automatic instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                   input reg_id_t rd, input reg_id_t ra, input reg_id_t rb);
    return {f7, rb, ra, f3, rd, op_op};
  endfunction

  function automatic instr_t enc_i(input opcode_t op, input logic [2:0] f3,
                                   input reg_id_t rd, input reg_id_t ra, input word_t imm);
    return {imm[11:0], ra, f3, rd, op};
  endfunction

  function automatic instr_t enc_s(input logic [2:0] f3, input reg_id_t ra,
                                   input reg_id_t rb, input word_t imm);
    return {imm[11:5], rb, ra, f3, imm[4:0], op_store};
  endfunction

  function automatic instr_t enc_b(input logic [2:0] f3, input reg_id_t ra,
                                   input reg_id_t rb, input word_t imm);
    return {imm[12], imm[10:5], rb, ra, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic instr_t enc_u(input opcode_t op, input reg_id_t rd, input word_t imm);
    return {imm[31:12], rd, op};
  endfunction

  function automatic instr_t enc_j(input reg_id_t rd, input word_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};  // Scrambled J layout
  endfunction

  task automatic add_row(input string name, input instr_t word, input encoding_t enc,
                         input alu_op_t op, input logic [5:0] flags, input reg_id_t rd,
                         input reg_id_t ra, input reg_id_t rb, input word_t imm);
    name_tab[row_count] = name;
    instr_tab[row_count] = word;
    enc_tab[row_count] = enc;
    alu_tab[row_count] = op;
    flag_tab[row_count] = flags;
    rd_tab[row_count] = rd;
    rs1_tab[row_count] = ra;
    rs2_tab[row_count] = rb;
    imm_tab[row_count] = imm;
    row_count++;
  endtask

  task automatic build_table();
    // Where a format lacks rd, rs1 or rs2 the expected index is the immediate bits in that slot
    add_row("add", enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), R_TYPE, ALU_ADD, fl_rw,
            5'd3, 5'd1, 5'd2, '0);
    add_row("sub", enc_r(7'h20, 3'b000, 5'd5, 5'd6, 5'd7), R_TYPE, ALU_SUB, fl_rw,
            5'd5, 5'd6, 5'd7, '0);
    add_row("sll", enc_r(7'h00, 3'b001, 5'd8, 5'd9, 5'd10), R_TYPE, ALU_SHIFT_LEFT, fl_rw,
            5'd8, 5'd9, 5'd10, '0);
    add_row("slt", enc_r(7'h00, 3'b010, 5'd11, 5'd12, 5'd13), R_TYPE, ALU_LESS_THAN_SIGNED,
            fl_rw, 5'd11, 5'd12, 5'd13, '0);
    add_row("sltu", enc_r(7'h00, 3'b011, 5'd14, 5'd15, 5'd16), R_TYPE, ALU_LESS_THAN_UNSIGNED,
            fl_rw, 5'd14, 5'd15, 5'd16, '0);
    add_row("xor", enc_r(7'h00, 3'b100, 5'd17, 5'd18, 5'd19), R_TYPE, ALU_XOR, fl_rw,
            5'd17, 5'd18, 5'd19, '0);
    add_row("srl", enc_r(7'h00, 3'b101, 5'd20, 5'd21, 5'd22), R_TYPE, ALU_SHIFT_RIGHT,
            fl_rw, 5'd20, 5'd21, 5'd22, '0);
    add_row("sra", enc_r(7'h20, 3'b101, 5'd23, 5'd24, 5'd25), R_TYPE, ALU_SHIFT_RIGHT_AR,
            fl_rw, 5'd23, 5'd24, 5'd25, '0);
    add_row("or", enc_r(7'h00, 3'b110, 5'd26, 5'd27, 5'd28), R_TYPE, ALU_OR, fl_rw,
            5'd26, 5'd27, 5'd28, '0);
    add_row("and", enc_r(7'h00, 3'b111, 5'd29, 5'd30, 5'd31), R_TYPE, ALU_AND, fl_rw,
            5'd29, 5'd30, 5'd31, '0);
    // Negative immediates prove the sign extension from bit 31
    add_row("addi", enc_i(op_op_imm, 3'b000, 5'd4, 5'd5, 32'hFFFF_FFFB), I_TYPE, ALU_ADD,
            fl_imm_rw, 5'd4, 5'd5, 5'd27, 32'hFFFF_FFFB);
    add_row("andi", enc_i(op_op_imm, 3'b111, 5'd12, 5'd13, 32'hFFFF_FFFF), I_TYPE, ALU_AND,
            fl_imm_rw, 5'd12, 5'd13, 5'd31, 32'hFFFF_FFFF);
    add_row("slli", enc_i(op_op_imm, 3'b001, 5'd1, 5'd2, 32'h3), I_TYPE, ALU_SHIFT_LEFT,
            fl_imm_rw, 5'd1, 5'd2, 5'd3, 32'h3);
    add_row("srai", enc_i(op_op_imm, 3'b101, 5'd6, 5'd7, 32'h404), I_TYPE, ALU_SHIFT_RIGHT_AR,
            fl_imm_rw, 5'd6, 5'd7, 5'd4, 32'h404);  // Upper immediate bits double as funct7
    add_row("lw", enc_i(op_load, 3'b010, 5'd10, 5'd2, 32'hFFFF_FFF0), I_TYPE, ALU_ADD,
            fl_load, 5'd10, 5'd2, 5'd16, 32'hFFFF_FFF0);
    add_row("jalr", enc_i(op_jalr, 3'b000, 5'd1, 5'd5, 32'h8), I_TYPE, ALU_ADD, fl_imm_rw,
            5'd1, 5'd5, 5'd8, 32'h8);
    add_row("sw", enc_s(3'b010, 5'd4, 5'd3, 32'hFFFF_FFDC), S_TYPE, ALU_ADD, fl_store,
            5'd28, 5'd4, 5'd3, 32'hFFFF_FFDC);
    add_row("beq", enc_b(3'b000, 5'd1, 5'd2, 32'hFFFF_FFF8), B_TYPE, ALU_SUB, fl_branch,
            5'd25, 5'd1, 5'd2, 32'hFFFF_FFF8);
    add_row("blt", enc_b(3'b100, 5'd5, 5'd6, 32'h7FE), B_TYPE, ALU_LESS_THAN_SIGNED,
            fl_branch, 5'd30, 5'd5, 5'd6, 32'h7FE);
    add_row("bltu", enc_b(3'b110, 5'd3, 5'd4, 32'h100), B_TYPE, ALU_LESS_THAN_UNSIGNED,
            fl_branch, 5'd0, 5'd3, 5'd4, 32'h100);
    add_row("lui", enc_u(op_lui, 5'd9, 32'hABCD_E000), U_TYPE, ALU_ADD, fl_imm_rw,
            5'd9, 5'd27, 5'd28, 32'hABCD_E000);
    add_row("auipc", enc_u(op_auipc, 5'd11, 32'h0001_2000), U_TYPE, ALU_ADD, fl_imm_rw,
            5'd11, 5'd2, 5'd0, 32'h0001_2000);
    add_row("jal back", enc_j(5'd1, 32'hFFFF_FFFC), J_TYPE, ALU_ADD, fl_imm_rw,
            5'd1, 5'd31, 5'd29, 32'hFFFF_FFFC);
    add_row("jal fwd", enc_j(5'd2, 32'h0001_2346), J_TYPE, ALU_ADD, fl_imm_rw,
            5'd2, 5'd2, 5'd6, 32'h0001_2346);
    add_row("unknown op", 32'hFFFF_FFFF, R_TYPE, ALU_ADD, fl_none,
            5'd31, 5'd31, 5'd31, '0);  // No such opcode
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  // Present one word for a cycle, then wait for it to reach decode
  task automatic fetch_and_wait(input string name, input instr_t word);
    int    edges;
    word_t tag;
    tag = exp_pc;
    instr_valid = 1'b1;
    instr_data = word;
    @(negedge clk);
    instr_valid = 1'b0;
    exp_pc = exp_pc + 32'd4;  // One word further on
    edges = 1;
    while (!id_valid) begin
      if (edges > max_wait) begin
        $display("Timeout in %s: id_valid never rose", name);
        $display("Some tests failed");
        $fatal(1);
      end
      @(negedge clk);
      edges++;
    end
    check_value({name, " latency"}, 32'd2, 32'(edges));
    check_value({name, " id_pc"}, tag, id_pc);
  endtask

  // A flushed or dropped word must never show up in decode
  task automatic expect_quiet(input string name);
    repeat (4) begin
      check_value({name, " id_valid"}, '0, 32'(id_valid));
      @(negedge clk);
    end
  endtask

  task automatic write_back(input reg_id_t id, input word_t data);
    reg_write = 1'b1;
    write_id = id;
    write_data = data;
    @(negedge clk);
    reg_write = 1'b0;
    if (id != 5'd0) reg_model[id] = data;  // x0 keeps its zero
  endtask

  initial begin
    reg_id_t ra;
    reg_id_t rb;
    word_t   value;
    word_t   target;
    instr_t  probe;
    rst_n = 1'b0;
    instr_valid = 1'b0;
    instr_data = '0;
    branch_taken = 1'b0;
    branch_target = '0;
    reg_write = 1'b0;
    write_id = '0;
    write_data = '0;
    exp_pc = '0;
    reg_model = '{default: '0};
    build_table();
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // Decode fields, immediates and sequential pc tags
    for (int i = 0; i < row_count; i++) begin
      fetch_and_wait(name_tab[i], instr_tab[i]);
      check_value({name_tab[i], " encoding"}, 32'(enc_tab[i]), 32'(encoding));
      check_value({name_tab[i], " alu_op"}, 32'(alu_tab[i]), 32'(alu_op));
      check_value({name_tab[i], " flags"}, 32'(flag_tab[i]),
                  32'({alu_src, mem_read, mem_write, mem_to_reg, is_branch, ctrl_reg_write}));
      check_value({name_tab[i], " write_back_id"}, 32'(rd_tab[i]), 32'(write_back_id));
      check_value({name_tab[i], " rs1"}, 32'(rs1_tab[i]), 32'(rs1));
      check_value({name_tab[i], " rs2"}, 32'(rs2_tab[i]), 32'(rs2));
      check_value({name_tab[i], " immediate"}, imm_tab[i], immediate_data);
    end

    // Branch in the same cycle as a new word drops that word
    probe = enc_r(7'h00, 3'b000, 5'd1, 5'd2, 5'd3);
    target = next_random() & ~32'h3;  // Word aligned target
    instr_valid = 1'b1;
    instr_data = probe;
    branch_taken = 1'b1;
    branch_target = target;
    @(negedge clk);
    instr_valid = 1'b0;
    branch_taken = 1'b0;
    expect_quiet("branch same cycle");
    exp_pc = target;
    fetch_and_wait("after branch", probe);

    // Branch while the word sits in fetch clears it before IF/ID
    target = next_random() & ~32'h3;
    instr_valid = 1'b1;
    instr_data = probe;
    @(negedge clk);
    instr_valid = 1'b0;
    branch_taken = 1'b1;
    branch_target = target;
    @(negedge clk);
    branch_taken = 1'b0;
    expect_quiet("flush in fetch");
    exp_pc = target;
    fetch_and_wait("after flush", probe);

    // Random values go into random nonzero registers and come back on both ports
    for (int k = 0; k < 6; k++) begin
      ra = reg_id_t'(((next_random() >> 16) % 31) + 1);
      rb = (ra == 5'd31) ? 5'd1 : ra + 5'd1;
      write_back(ra, next_random());
      write_back(rb, next_random());
      fetch_and_wait("regfile read", enc_r(7'h00, 3'b000, 5'd0, ra, rb));
      check_value("regfile read1", reg_model[ra], read1_data);
      check_value("regfile read2", reg_model[rb], read2_data);
    end

    write_back(5'd0, next_random());
    fetch_and_wait("x0 read", enc_r(7'h00, 3'b000, 5'd1, 5'd0, 5'd0));
    check_value("x0 read1", '0, read1_data);
    check_value("x0 read2", '0, read2_data);

    // Bypass is sampled a quarter cycle after driving and well before the write edge
    fetch_and_wait("bypass", enc_r(7'h00, 3'b000, 5'd0, ra, rb));
    value = next_random();
    reg_write = 1'b1;
    write_id = ra;
    write_data = value;
    #(clk_period / 4);
    check_value("bypass read1", value, read1_data);
    check_value("bypass read2 untouched", reg_model[rb], read2_data);
    @(negedge clk);
    reg_write = 1'b0;
    reg_model[ra] = value;
    check_value("landed read1", value, read1_data);
    value = next_random();
    reg_write = 1'b1;
    write_id = rb;
    write_data = value;
    #(clk_period / 4);
    check_value("bypass read2", value, read2_data);
    @(negedge clk);
    reg_write = 1'b0;
    check_value("landed read2", value, read2_data);

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
hdl/core_pkg.sv
hdl/isa_pkg.sv
hdl/fetch_if.sv
hdl/control_if.sv
hdl/fetch_unit.sv
hdl/if_id_register.sv
hdl/control.sv
hdl/imm_gen.sv
hdl/registers.sv
hdl/instruction_decode_stage.sv
hdl/decode_top.sv
tb/decode_top_tb.sv

// File: Bender.yml
package:
  name: rv32i_decode

sources:
  - files:
      - hdl/core_pkg.sv
      - hdl/isa_pkg.sv
      - hdl/fetch_if.sv
      - hdl/control_if.sv
      - hdl/fetch_unit.sv
      - hdl/if_id_register.sv
      - hdl/control.sv
      - hdl/imm_gen.sv
      - hdl/registers.sv
      - hdl/instruction_decode_stage.sv
      - hdl/decode_top.sv
  - target: simulation
    files:
      - tb/decode_top_tb.sv
